//--- alu.sv
// 32-bit integer ALU for the RV32I base operations.
// Purely combinational, with a zero flag used for branch decisions.
module alu (
    input  logic [4:0]                 alu_function,
    input  logic [riscv_pkg::XLEN-1:0] operand_a,
    input  logic [riscv_pkg::XLEN-1:0] operand_b,
    output logic [riscv_pkg::XLEN-1:0] result,
    output logic                       result_equal_zero
);

    logic [4:0] shamt;

    assign shamt = operand_b[4:0];

    always_comb begin
        case (alu_function)
            riscv_pkg::ALU_ADD:  result = operand_a + operand_b;
            riscv_pkg::ALU_SUB:  result = operand_a - operand_b;
            riscv_pkg::ALU_SLL:  result = operand_a << shamt;
            riscv_pkg::ALU_SLT:  result = {31'b0, $signed(operand_a) < $signed(operand_b)};
            riscv_pkg::ALU_SLTU: result = {31'b0, operand_a < operand_b};
            riscv_pkg::ALU_XOR:  result = operand_a ^ operand_b;
            riscv_pkg::ALU_SRL:  result = operand_a >> shamt;
            riscv_pkg::ALU_SRA:  result = $unsigned($signed(operand_a) >>> shamt);
            riscv_pkg::ALU_OR:   result = operand_a | operand_b;
            riscv_pkg::ALU_AND:  result = operand_a & operand_b;
            default:             result = '0;
        endcase
    end

    assign result_equal_zero = (result == '0);

endmodule

//--- alu_control.sv
// ALU decoder.
// Turns the operation class plus funct3 and funct7 into an ALU function code.
module alu_control (
    input  logic [1:0] alu_op_type,
    input  logic [2:0] inst_funct3,
    input  logic [6:0] inst_funct7,
    output logic [4:0] alu_function
);

    always_comb begin
        alu_function = riscv_pkg::ALU_ADD;
        case (alu_op_type)
            riscv_pkg::ALU_OP_BRANCH: begin
                case (inst_funct3[2:1])
                    2'b10:   alu_function = riscv_pkg::ALU_SLT;  // BLT and BGE.
                    2'b11:   alu_function = riscv_pkg::ALU_SLTU;
                    default: alu_function = riscv_pkg::ALU_SUB;  // BEQ and BNE.
                endcase
            end
            riscv_pkg::ALU_OP_IMM, riscv_pkg::ALU_OP_REG: begin
                case (inst_funct3)
                    3'b000: begin
                        // there is no SUBI, so bit 5 only counts for register operands.
                        if (alu_op_type == riscv_pkg::ALU_OP_REG && inst_funct7[5])
                            alu_function = riscv_pkg::ALU_SUB;
                        else
                            alu_function = riscv_pkg::ALU_ADD;
                    end
                    3'b001: alu_function = riscv_pkg::ALU_SLL;
                    3'b010: alu_function = riscv_pkg::ALU_SLT;
                    3'b011: alu_function = riscv_pkg::ALU_SLTU;
                    3'b100: alu_function = riscv_pkg::ALU_XOR;
                    3'b101: alu_function = inst_funct7[5] ? riscv_pkg::ALU_SRA
                                                          : riscv_pkg::ALU_SRL;
                    3'b110: alu_function = riscv_pkg::ALU_OR;
                    default: alu_function = riscv_pkg::ALU_AND;
                endcase
            end
            default: alu_function = riscv_pkg::ALU_ADD;
        endcase
    end

endmodule

//--- regfile.sv
// Integer register file, x0 to x31.
// Two combinational read ports and one write port on the rising clock edge.
module regfile (
    input  logic                       clock,
    input  logic                       write_enable,
    input  logic [4:0]                 rd_address,
    input  logic [4:0]                 rs1_address,
    input  logic [4:0]                 rs2_address,
    input  logic [riscv_pkg::XLEN-1:0] rd_data,
    output logic [riscv_pkg::XLEN-1:0] rs1_data,
    output logic [riscv_pkg::XLEN-1:0] rs2_data
);

    logic [riscv_pkg::XLEN-1:0] regs [32];

    always_ff @(posedge clock) begin
        if (write_enable && rd_address != 5'd0)
            regs[rd_address] <= rd_data;
    end

    // x0 is never written, so its reads are forced to zero here.
    assign rs1_data = (rs1_address == 5'd0) ? '0 : regs[rs1_address];
    assign rs2_data = (rs2_address == 5'd0) ? '0 : regs[rs2_address];

endmodule

//--- riscv_core.sv
// Top level of the single-cycle RV32I core.
// Joins control path and datapath; instruction and data memories sit outside.
module riscv_core (
    input  logic                       clock,
    input  logic                       rst,
    input  logic [31:0]                inst_data,
    input  logic                       inst_available,
    input  logic [riscv_pkg::XLEN-1:0] data_read_data,
    input  logic                       data_available,
    output logic [riscv_pkg::XLEN-1:0] inst_addr,
    output logic [riscv_pkg::XLEN-1:0] data_addr,
    output logic [riscv_pkg::XLEN-1:0] data_write_data,
    output logic                       data_read_enable,
    output logic                       data_write_enable
);

    riscv_pkg::inst_t inst;
    logic             pc_write_enable;
    logic             regfile_write_enable;
    logic             alu_operand_a_select;
    logic             alu_operand_b_select;
    logic             alu_result_equal_zero;
    logic [2:0]       reg_writeback_select;
    logic [4:0]       alu_function;
    logic [1:0]       next_pc_select;

    assign inst = inst_data;

    singlecycle_ctlpath u_ctlpath (
        .inst_opcode           (inst.r.opcode),
        .inst_funct3           (inst.r.funct3),
        .inst_funct7           (inst.r.funct7),
        .alu_result_equal_zero (alu_result_equal_zero),
        .inst_available        (inst_available),
        .data_available        (data_available),
        .pc_write_enable       (pc_write_enable),
        .regfile_write_enable  (regfile_write_enable),
        .alu_operand_a_select  (alu_operand_a_select),
        .alu_operand_b_select  (alu_operand_b_select),
        .data_mem_read_enable  (data_read_enable),
        .data_mem_write_enable (data_write_enable),
        .reg_writeback_select  (reg_writeback_select),
        .alu_function          (alu_function),
        .next_pc_select        (next_pc_select)
    );

    singlecycle_datapath u_datapath (
        .clock                 (clock),
        .rst                   (rst),
        .inst_data             (inst_data),
        .data_read_data        (data_read_data),
        .pc_write_enable       (pc_write_enable),
        .regfile_write_enable  (regfile_write_enable),
        .alu_operand_a_select  (alu_operand_a_select),
        .alu_operand_b_select  (alu_operand_b_select),
        .reg_writeback_select  (reg_writeback_select),
        .alu_function          (alu_function),
        .next_pc_select        (next_pc_select),
        .inst_addr             (inst_addr),
        .data_addr             (data_addr),
        .data_write_data       (data_write_data),
        .alu_result_equal_zero (alu_result_equal_zero)
    );

endmodule

//--- riscv_pkg.sv
// Shared constants and the instruction word type for the single-cycle RV32I core.
// Every design file refers to these through riscv_pkg:: scoped names.
package riscv_pkg;

    localparam int XLEN = 32;
    localparam logic [XLEN-1:0] RESET_VECTOR = 32'h0000_0000;

    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE  = 7'b0100011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;

    // operation class handed from the main decoder to the ALU decoder.
    localparam logic [1:0] ALU_OP_ADD    = 2'd0;
    localparam logic [1:0] ALU_OP_BRANCH = 2'd1;
    localparam logic [1:0] ALU_OP_IMM    = 2'd2;
    localparam logic [1:0] ALU_OP_REG    = 2'd3;

    localparam logic [4:0] ALU_ADD  = 5'd0;
    localparam logic [4:0] ALU_SUB  = 5'd1;
    localparam logic [4:0] ALU_SLL  = 5'd2;
    localparam logic [4:0] ALU_SLT  = 5'd3;
    localparam logic [4:0] ALU_SLTU = 5'd4;
    localparam logic [4:0] ALU_XOR  = 5'd5;
    localparam logic [4:0] ALU_SRL  = 5'd6;
    localparam logic [4:0] ALU_SRA  = 5'd7;
    localparam logic [4:0] ALU_OR   = 5'd8;
    localparam logic [4:0] ALU_AND  = 5'd9;

    localparam logic [2:0] WB_ALU  = 3'd0;
    localparam logic [2:0] WB_DATA = 3'd1;
    localparam logic [2:0] WB_IMM  = 3'd2;
    localparam logic [2:0] WB_PC4  = 3'd3;

    localparam logic [1:0] NEXT_PC_PLUS4  = 2'd0;
    localparam logic [1:0] NEXT_PC_BRANCH = 2'd1;
    localparam logic [1:0] NEXT_PC_JAL    = 2'd2;
    localparam logic [1:0] NEXT_PC_JALR   = 2'd3;

    localparam logic OPA_RS1 = 1'b0;
    localparam logic OPA_PC  = 1'b1;
    localparam logic OPB_RS2 = 1'b0;
    localparam logic OPB_IMM = 1'b1;

    // one instruction word seen through each of the six base formats.
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } inst_t;

endpackage

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f sources.f --top-module tb_riscv_core -o sim_tb
out=$(./obj_dir/sim_tb 2>&1) || true
echo "$out"
if echo "$out" | grep -qx "No errors"; then
    exit 0
else
    exit 1
fi

//--- singlecycle_control.sv
// Main opcode decoder of the single-cycle core.
// Produces the raw enables and selects before any availability gating.
module singlecycle_control (
    input  logic [6:0] inst_opcode,
    input  logic       take_branch,
    output logic       pc_write_enable,
    output logic       regfile_write_enable,
    output logic       alu_operand_a_select,
    output logic       alu_operand_b_select,
    output logic [1:0] alu_op_type,
    output logic       data_mem_read_enable,
    output logic       data_mem_write_enable,
    output logic [2:0] reg_writeback_select,
    output logic [1:0] next_pc_select
);

    always_comb begin
        // unknown opcodes fall through as a plain PC step with nothing written.
        pc_write_enable       = 1'b1;
        regfile_write_enable  = 1'b0;
        alu_operand_a_select  = riscv_pkg::OPA_RS1;
        alu_operand_b_select  = riscv_pkg::OPB_RS2;
        alu_op_type           = riscv_pkg::ALU_OP_ADD;
        data_mem_read_enable  = 1'b0;
        data_mem_write_enable = 1'b0;
        reg_writeback_select  = riscv_pkg::WB_ALU;
        next_pc_select        = riscv_pkg::NEXT_PC_PLUS4;

        case (inst_opcode)
            riscv_pkg::OPCODE_LUI: begin
                regfile_write_enable = 1'b1;
                reg_writeback_select = riscv_pkg::WB_IMM;
            end
            riscv_pkg::OPCODE_AUIPC: begin
                regfile_write_enable = 1'b1;
                alu_operand_a_select = riscv_pkg::OPA_PC;
                alu_operand_b_select = riscv_pkg::OPB_IMM;
            end
            riscv_pkg::OPCODE_JAL: begin
                regfile_write_enable = 1'b1;
                reg_writeback_select = riscv_pkg::WB_PC4;
                next_pc_select       = riscv_pkg::NEXT_PC_JAL;
            end
            riscv_pkg::OPCODE_JALR: begin
                regfile_write_enable = 1'b1;
                alu_operand_b_select = riscv_pkg::OPB_IMM; // target comes from the ALU sum.
                reg_writeback_select = riscv_pkg::WB_PC4;
                next_pc_select       = riscv_pkg::NEXT_PC_JALR;
            end
            riscv_pkg::OPCODE_BRANCH: begin
                alu_op_type    = riscv_pkg::ALU_OP_BRANCH;
                next_pc_select = take_branch ? riscv_pkg::NEXT_PC_BRANCH
                                             : riscv_pkg::NEXT_PC_PLUS4;
            end
            riscv_pkg::OPCODE_LOAD: begin
                regfile_write_enable = 1'b1;
                alu_operand_b_select = riscv_pkg::OPB_IMM;
                data_mem_read_enable = 1'b1;
                reg_writeback_select = riscv_pkg::WB_DATA;
            end
            riscv_pkg::OPCODE_STORE: begin
                alu_operand_b_select  = riscv_pkg::OPB_IMM;
                data_mem_write_enable = 1'b1;
            end
            riscv_pkg::OPCODE_OP_IMM: begin
                regfile_write_enable = 1'b1;
                alu_operand_b_select = riscv_pkg::OPB_IMM;
                alu_op_type          = riscv_pkg::ALU_OP_IMM;
            end
            riscv_pkg::OPCODE_OP: begin
                regfile_write_enable = 1'b1;
                alu_op_type          = riscv_pkg::ALU_OP_REG;
            end
            default: begin
            end
        endcase
    end

endmodule

//--- singlecycle_ctlpath.sv
// Control path of the single-cycle core.
// Gates the decoded enables with memory availability and makes the branch decision.
module singlecycle_ctlpath (
    input  logic [6:0] inst_opcode,
    input  logic [2:0] inst_funct3,
    input  logic [6:0] inst_funct7,
    input  logic       alu_result_equal_zero,
    input  logic       inst_available,
    input  logic       data_available,
    output logic       pc_write_enable,
    output logic       regfile_write_enable,
    output logic       alu_operand_a_select,
    output logic       alu_operand_b_select,
    output logic       data_mem_read_enable,
    output logic       data_mem_write_enable,
    output logic [2:0] reg_writeback_select,
    output logic [4:0] alu_function,
    output logic [1:0] next_pc_select
);

    logic       take_branch;
    logic       inst_done;
    logic [1:0] alu_op_type;
    logic       pc_write_enable_raw;
    logic       regfile_write_enable_raw;
    logic       data_mem_read_enable_raw;
    logic       data_mem_write_enable_raw;

    // EQ/NE compare with SUB, the others with SLT/SLTU; funct3[0] inverts the sense.
    assign take_branch = (inst_funct3[2] ? !alu_result_equal_zero : alu_result_equal_zero)
                         ^ inst_funct3[0];

    // a load is only complete once its data has come back.
    assign inst_done = inst_available && (data_available || !data_mem_read_enable_raw);

    assign pc_write_enable       = inst_done && pc_write_enable_raw;
    assign regfile_write_enable  = inst_available && regfile_write_enable_raw;
    assign data_mem_read_enable  = inst_available && data_mem_read_enable_raw;
    assign data_mem_write_enable = inst_available && data_mem_write_enable_raw;

    singlecycle_control u_control (
        .inst_opcode           (inst_opcode),
        .take_branch           (take_branch),
        .pc_write_enable       (pc_write_enable_raw),
        .regfile_write_enable  (regfile_write_enable_raw),
        .alu_operand_a_select  (alu_operand_a_select),
        .alu_operand_b_select  (alu_operand_b_select),
        .alu_op_type           (alu_op_type),
        .data_mem_read_enable  (data_mem_read_enable_raw),
        .data_mem_write_enable (data_mem_write_enable_raw),
        .reg_writeback_select  (reg_writeback_select),
        .next_pc_select        (next_pc_select)
    );

    alu_control u_alu_control (
        .alu_op_type  (alu_op_type),
        .inst_funct3  (inst_funct3),
        .inst_funct7  (inst_funct7),
        .alu_function (alu_function)
    );

endmodule

//--- singlecycle_datapath.sv
// Datapath of the single-cycle core.
// Holds the PC, builds immediates, muxes ALU operands and writeback, picks the next PC.
module singlecycle_datapath (
    input  logic                       clock,
    input  logic                       rst,
    input  logic [31:0]                inst_data,
    input  logic [riscv_pkg::XLEN-1:0] data_read_data,
    input  logic                       pc_write_enable,
    input  logic                       regfile_write_enable,
    input  logic                       alu_operand_a_select,
    input  logic                       alu_operand_b_select,
    input  logic [2:0]                 reg_writeback_select,
    input  logic [4:0]                 alu_function,
    input  logic [1:0]                 next_pc_select,
    output logic [riscv_pkg::XLEN-1:0] inst_addr,
    output logic [riscv_pkg::XLEN-1:0] data_addr,
    output logic [riscv_pkg::XLEN-1:0] data_write_data,
    output logic                       alu_result_equal_zero
);

    riscv_pkg::inst_t           inst;
    logic [riscv_pkg::XLEN-1:0] pc;
    logic [riscv_pkg::XLEN-1:0] pc_plus4;
    logic [riscv_pkg::XLEN-1:0] next_pc;
    logic [riscv_pkg::XLEN-1:0] imm;
    logic [riscv_pkg::XLEN-1:0] rs1_data;
    logic [riscv_pkg::XLEN-1:0] rs2_data;
    logic [riscv_pkg::XLEN-1:0] operand_a;
    logic [riscv_pkg::XLEN-1:0] operand_b;
    logic [riscv_pkg::XLEN-1:0] alu_result;
    logic [riscv_pkg::XLEN-1:0] rd_data;

    assign inst = inst_data;

    always_comb begin
        case (inst.r.opcode)
            riscv_pkg::OPCODE_LUI, riscv_pkg::OPCODE_AUIPC:
                imm = {inst.u.imm_31_12, 12'b0};
            riscv_pkg::OPCODE_JAL:
                imm = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                       inst.j.imm_11, inst.j.imm_10_1, 1'b0};
            riscv_pkg::OPCODE_BRANCH:
                imm = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                       inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
            riscv_pkg::OPCODE_STORE:
                imm = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
            default:
                imm = {{20{inst.i.imm_11_0[11]}}, inst.i.imm_11_0}; // loads, OP-IMM, JALR.
        endcase
    end

    regfile u_regfile (
        .clock        (clock),
        .write_enable (regfile_write_enable),
        .rd_address   (inst.r.rd),
        .rs1_address  (inst.r.rs1),
        .rs2_address  (inst.r.rs2),
        .rd_data      (rd_data),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data)
    );

    assign operand_a = (alu_operand_a_select == riscv_pkg::OPA_PC) ? pc : rs1_data;
    assign operand_b = (alu_operand_b_select == riscv_pkg::OPB_IMM) ? imm : rs2_data;

    alu u_alu (
        .alu_function      (alu_function),
        .operand_a         (operand_a),
        .operand_b         (operand_b),
        .result            (alu_result),
        .result_equal_zero (alu_result_equal_zero)
    );

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (reg_writeback_select)
            riscv_pkg::WB_DATA: rd_data = data_read_data;
            riscv_pkg::WB_IMM:  rd_data = imm;
            riscv_pkg::WB_PC4:  rd_data = pc_plus4;
            default:            rd_data = alu_result;
        endcase
    end

    // the ALU is busy comparing during a branch, so targets get their own adder.
    always_comb begin
        case (next_pc_select)
            riscv_pkg::NEXT_PC_BRANCH, riscv_pkg::NEXT_PC_JAL: next_pc = pc + imm;
            riscv_pkg::NEXT_PC_JALR: next_pc = {alu_result[31:1], 1'b0};
            default:                 next_pc = pc_plus4;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst)
            pc <= riscv_pkg::RESET_VECTOR;
        else if (pc_write_enable)
            pc <= next_pc;
    end

    assign inst_addr       = pc;
    assign data_addr       = alu_result;
    assign data_write_data = rs2_data;

endmodule

//--- sources.f
riscv_pkg.sv
alu.sv
regfile.sv
alu_control.sv
singlecycle_control.sv
singlecycle_ctlpath.sv
singlecycle_datapath.sv
riscv_core.sv
tb_riscv_core.sv

//--- tb_riscv_core.sv
// Testbench for the single-cycle RV32I core.
// Runs a table of small programs against behavioral memories with random latency;
// each program stores its result to 0x100 and then jumps to itself.
module tb_riscv_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_PROGS = 8;
    localparam int CYCLE_LIMIT = NUM_PROGS * 12 * 8 * 2;

    logic clock, rst, inst_available, data_available;
    logic [31:0] inst_data, data_read_data;
    logic [31:0] inst_addr, data_addr, data_write_data;
    logic data_read_enable, data_write_enable;

    logic [31:0] imem [16];
    logic [31:0] dmem [256];
    logic [31:0] rng, cur_addr;
    logic [31:0] snap_pc, snap_addr, snap_wdata;
    logic [31:0] last_store_addr, last_store_data;
    logic snap_valid, snap_we, snap_re, data_pending, store_seen, done;
    logic [1:0] inst_wait, data_wait;
    int cycles;

    // one program per row. the branch rows compare x1 with x2 for (-1,1), (1,1), (-1,1) and (1,-1).
    logic [31:0] programs [NUM_PROGS][12] = '{
        '{32'h00500013, 32'hFF900093, 32'h00300113, 32'h402081B3, 32'h4021D233, 32'h002112B3,
          32'h00113333, 32'h005243B3, 32'h0063E433, 32'h00147533, 32'h10A02023, 32'h0000006F},
        '{32'h04002503, 32'h04402583, 32'h00B50533, 32'h10A02023, 32'h0000006F, 32'h0000006F,
          32'h0000006F, 32'h0000006F, 32'h0000006F, 32'h0000006F, 32'h0000006F, 32'h0000006F},
        '{32'h00000513, 32'hFFF00093, 32'h00100113, 32'h00208463, 32'h00150513, 32'h00209463,
          32'h00250513, 32'h0020C463, 32'h00450513, 32'h10A02023, 32'h0000006F, 32'h0000006F},
        '{32'h00000513, 32'h00100093, 32'h00100113, 32'h00208463, 32'h00150513, 32'h00209463,
          32'h00250513, 32'h0020C463, 32'h00450513, 32'h10A02023, 32'h0000006F, 32'h0000006F},
        '{32'h00000513, 32'hFFF00093, 32'h00100113, 32'h0020D463, 32'h00150513, 32'h0020E463,
          32'h00250513, 32'h0020F463, 32'h00450513, 32'h10A02023, 32'h0000006F, 32'h0000006F},
        '{32'h00000513, 32'h00100093, 32'hFFF00113, 32'h0020D463, 32'h00150513, 32'h0020E463,
          32'h00250513, 32'h0020F463, 32'h00450513, 32'h10A02023, 32'h0000006F, 32'h0000006F},
        '{32'h008000EF, 32'h00150513, 32'h00D082E7, 32'h00150513, 32'h00829313, 32'h00136533,
          32'h10A02023, 32'h0000006F, 32'h0000006F, 32'h0000006F, 32'h0000006F, 32'h0000006F},
        '{32'h123450B7, 32'h00001117, 32'h00208533, 32'h10A02023, 32'h0000006F, 32'h0000006F,
          32'h0000006F, 32'h0000006F, 32'h0000006F, 32'h0000006F, 32'h0000006F, 32'h0000006F}
    };
    logic [31:0] expected_addr [NUM_PROGS] = '{8{32'h0000_0100}};
    logic [31:0] expected_data [NUM_PROGS] = '{
        32'hFFFFFFE1, 32'h0085FF7A, 32'h00000001, 32'h00000006,
        32'h00000003, 32'h00000004, 32'h00000C04, 32'h12346004
    };

    riscv_core dut (
        .clock             (clock),
        .rst               (rst),
        .inst_data         (inst_data),
        .inst_available    (inst_available),
        .data_read_data    (data_read_data),
        .data_available    (data_available),
        .inst_addr         (inst_addr),
        .data_addr         (data_addr),
        .data_write_data   (data_write_data),
        .data_read_enable  (data_read_enable),
        .data_write_enable (data_write_enable)
    );

    always #4 clock = ~clock;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] v;
        v = x ^ (x << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            report_failure("mismatch on a stored word");
        end
    endtask

    task automatic check_pc(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] inst_addr: got %h, expected %h", got, exp);
            report_failure("PC wrong at reset");
        end
    endtask

    // called once per falling edge to commit stores and then drive both memory responses.
    task automatic serve_memories();
        if (snap_valid && inst_addr != snap_pc && snap_we) begin
            dmem[snap_addr[9:2]] = snap_wdata;
            last_store_addr = snap_addr;
            last_store_data = snap_wdata;
            store_seen = 1'b1;
        end
        if (inst_addr != cur_addr) begin // a new fetch starts.
            if (inst_addr[1:0] != 2'b00)
                report_failure("instruction fetch from an address that is not word aligned");
            cur_addr = inst_addr;
            rng = xorshift(rng);
            inst_wait = rng[1:0];
            data_pending = 1'b0;
            data_available = 1'b0;
        end
        if (inst_wait == 2'd0) begin
            inst_available = 1'b1;
            inst_data = imem[cur_addr[5:2]];
        end else begin
            inst_wait = inst_wait - 2'd1;
            inst_available = 1'b0;
        end
        if (data_pending) begin
            if (data_wait == 2'd0) begin
                data_available = 1'b1;
                data_read_data = dmem[snap_addr[9:2]];
            end else begin
                data_wait = data_wait - 2'd1;
            end
        end else if (snap_valid && snap_re && snap_pc == cur_addr) begin
            rng = xorshift(rng);
            data_wait = rng[1:0];
            data_pending = 1'b1;
        end
    endtask

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT)
            report_failure("timeout: a program never reached its final self-jump");
    end

    initial begin
        clock = 1'b0;
        rst = 1'b1;
        inst_available = 1'b0;
        data_available = 1'b0;
        inst_data = 32'h0;
        data_read_data = 32'h0;
        rng = 32'd49;
        cycles = 0;
        for (int p = 0; p < NUM_PROGS; p++) begin
            @(negedge clock);
            rst = 1'b1;
            inst_available = 1'b0;
            data_available = 1'b0;
            inst_data = 32'h10A02023; // a store word that must stay off the bus.
            for (int i = 0; i < 16; i++)
                imem[i] = (i < 12) ? programs[p][i] : 32'h0000006F;
            for (int i = 0; i < 256; i++)
                dmem[i] = {i[13:0], 2'b00, ~{i[13:0], 2'b00}}; // upper half address, lower inverted.
            repeat (4) @(negedge clock);
            check_pc(inst_addr, riscv_pkg::RESET_VECTOR);
            if (data_write_enable || data_read_enable)
                report_failure("memory request issued during reset");
            rst = 1'b0;
            cur_addr = 32'hFFFF_FFFF;
            snap_valid = 1'b0;
            store_seen = 1'b0;
            done = 1'b0;
            while (!done) begin
                serve_memories();
                #1;
                snap_pc = inst_addr;
                snap_we = data_write_enable;
                snap_re = data_read_enable;
                snap_addr = data_addr;
                snap_wdata = data_write_data;
                snap_valid = 1'b1;
                if (!inst_available && (data_write_enable || data_read_enable))
                    report_failure("data memory enabled while no instruction was available");
                if (inst_available && inst_data == 32'h0000006F)
                    done = 1'b1;
                else
                    @(negedge clock);
            end
            if (!store_seen)
                report_failure("program ended without committing a store");
            check_word("data_addr", last_store_addr, expected_addr[p]);
            check_word("data_write_data", last_store_data, expected_data[p]);
        end
        $display("No errors");
        $finish;
    end

endmodule
